// File: include/board_settings.svh
// board glue settings
// divider counts, fan PWM prescale and pad synchronizer depth

`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////////////
// rtc divider
//////////////////////////////////////////////////////////////////////////////

// soc_clk cycles per rtc half period, 50 MHz / 50 = 1 MHz
`define RTC_DIV_HALF 25

//////////////////////////////////////////////////////////////////////////////
// fan pwm
//////////////////////////////////////////////////////////////////////////////

// soc_clk cycles per pwm step
`define FAN_PRESCALE 4
// steps per pwm period, one per switch code above zero
`define FAN_STEPS 15

// flops per asynchronous pad input
`define PAD_SYNC_STAGES 2

`endif

// File: design/board_timing_pkg.sv
// board timing types
// counter and setting types for the rtc divider and the fan PWM

package board_timing_pkg;

  //////////////////////////////////////////////////////////////////////////
  // rtc divider
  //////////////////////////////////////////////////////////////////////////

  // half period counter, holds 0 .. RTC_DIV_HALF-1
  typedef logic [4:0] rtc_cnt_t;

  //////////////////////////////////////////////////////////////////////////
  // fan pwm
  //////////////////////////////////////////////////////////////////////////

  // raw value of the four fan switches
  typedef logic [3:0] fan_setting_t;

  // step within one pwm period, 0 .. FAN_STEPS-1
  typedef logic [3:0] fan_step_t;

  // cycles within one step, 0 .. FAN_PRESCALE-1
  typedef logic [1:0] fan_presc_t;

endpackage

// File: design/board_pads_pkg.sv
// board pad types
// SoC-side vector types for the SPI host and its pad mapping

package board_pads_pkg;

  //////////////////////////////////////////////////////////////////////////
  // spi host side
  //////////////////////////////////////////////////////////////////////////

  // chip selects, active low on the wire
  // bit 0 goes to the sd card as DAT3
  // bit 1 has no pad on this board
  typedef logic [1:0] spi_cs_t;

  // data lines in quad layout
  // bit 0 is MOSI and drives CMD
  // bit 1 is MISO and comes back from DAT0
  // bits 2 and 3 stay unused in spi mode
  typedef logic [3:0] spi_sd_t;

  // i2c needs no vector type
  // scl and sda travel as single bits with their enables

endpackage

// File: design/rtc_divider.sv
// rtc divider
// divides soc_clk by 2 * RTC_DIV_HALF into a square wave for the SoC rtc

`timescale 1ns/1ps

`include "board_settings.svh"

module rtc_divider (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  // last count of a half period
  localparam board_timing_pkg::rtc_cnt_t cnt_last =
    board_timing_pkg::rtc_cnt_t'(`RTC_DIV_HALF - 1);

  board_timing_pkg::rtc_cnt_t cnt_d;
  board_timing_pkg::rtc_cnt_t cnt_q;
  logic                       rtc_d;
  logic                       rtc_q;

  //////////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    // free running by default
    cnt_d = cnt_q + board_timing_pkg::rtc_cnt_t'(1);
    rtc_d = rtc_q;
    // half period done, flip the level
    if (cnt_q == cnt_last) begin
      cnt_d = '0;
      rtc_d = ~rtc_q;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////////

  // first toggle lands RTC_DIV_HALF edges after reset release
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      rtc_q <= rtc_d;
    end
  end

  // straight from the flop, no glitches on the rtc input
  assign rtc_o = rtc_q;

endmodule

// File: design/fan_pwm.sv
// fan PWM controller
// turns the four fan switches into a duty cycle of setting / FAN_STEPS
// new switch values take effect at the start of the next period

`timescale 1ns/1ps

`include "board_settings.svh"

module fan_pwm (
  input  logic                           soc_clk,
  input  logic                           rst_n,
  input  board_timing_pkg::fan_setting_t fan_sw_i,
  output logic                           fan_pwm_o
);

  // terminal counts
  localparam board_timing_pkg::fan_presc_t presc_last_val =
    board_timing_pkg::fan_presc_t'(`FAN_PRESCALE - 1);
  localparam board_timing_pkg::fan_step_t step_last_val =
    board_timing_pkg::fan_step_t'(`FAN_STEPS - 1);

  board_timing_pkg::fan_presc_t   presc_q;
  board_timing_pkg::fan_step_t    step_q;
  board_timing_pkg::fan_setting_t setting_q;
  logic                           presc_last;
  logic                           step_last;
  logic                           period_wrap;
  logic                           pwm_q;

  //////////////////////////////////////////////////////////////////////////
  // period timing
  //////////////////////////////////////////////////////////////////////////

  // step advances once per prescale round
  assign presc_last  = (presc_q == presc_last_val);
  assign step_last   = (step_q == step_last_val);
  // last cycle of the whole period
  assign period_wrap = presc_last & step_last;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q <= '0;
      step_q  <= '0;
    end else begin
      if (presc_last) begin
        presc_q <= '0;
        // step wraps from FAN_STEPS-1 back to 0
        if (step_last) begin
          step_q <= '0;
        end else begin
          step_q <= step_q + board_timing_pkg::fan_step_t'(1);
        end
      end else begin
        presc_q <= presc_q + board_timing_pkg::fan_presc_t'(1);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // setting shadow and output
  //////////////////////////////////////////////////////////////////////////

  // switches only sampled at the wrap
  // mid-period changes cannot chop a pulse
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      setting_q <= '0;
    end else if (period_wrap) begin
      setting_q <= fan_sw_i;
    end
  end

  // high for the first setting steps of each period
  // setting 15 never drops, setting 0 never rises
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (step_q < setting_q);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

// File: design/pad_adapter.sv
// pad adapter
// maps the SoC SPI host onto the SD card pins in SPI mode, passes the
// I2C output/enable pairs to the pads, and synchronizes the pad inputs

`timescale 1ns/1ps

`include "board_settings.svh"

module pad_adapter (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  // spi, SoC side
  input  logic                    spi_sck_i,
  input  logic                    spi_sck_en_i,
  input  board_pads_pkg::spi_cs_t spi_cs_i,
  input  board_pads_pkg::spi_cs_t spi_cs_en_i,
  input  board_pads_pkg::spi_sd_t spi_sd_i,
  input  board_pads_pkg::spi_sd_t spi_sd_en_i,
  output board_pads_pkg::spi_sd_t spi_sd_o,
  // sd card pins
  output logic                    sd_sclk_o,
  output logic                    sd_cmd_o,
  output logic                    sd_dat3_o,
  input  logic                    sd_dat0_i,
  input  logic                    sd_cd_i,
  output logic                    card_detect_o,
  // i2c, SoC side
  input  logic                    i2c_scl_i,
  input  logic                    i2c_scl_en_i,
  input  logic                    i2c_sda_i,
  input  logic                    i2c_sda_en_i,
  // i2c pads
  output logic                    scl_pad_o,
  output logic                    scl_oe_o,
  output logic                    sda_pad_o,
  output logic                    sda_oe_o,
  input  logic                    scl_pad_i,
  input  logic                    sda_pad_i,
  // i2c, synchronized back to the SoC
  output logic                    i2c_scl_o,
  output logic                    i2c_sda_o
);

  localparam int unsigned sync_stages = `PAD_SYNC_STAGES;

  // lanes of the synchronizer vector
  localparam int unsigned lane_miso = 0;
  localparam int unsigned lane_scl  = 1;
  localparam int unsigned lane_sda  = 2;
  localparam int unsigned lane_cd   = 3;
  localparam int unsigned lanes     = 4;

  logic [lanes-1:0]                  pad_async;
  logic [sync_stages-1:0][lanes-1:0] sync_q;
  logic [lanes-1:0]                  pad_sync;

  //////////////////////////////////////////////////////////////////////////
  // sd card in spi mode
  //////////////////////////////////////////////////////////////////////////

  // undriven lines idle high, card sees no clock and no select
  // SCK -> sd CLK
  assign sd_sclk_o = spi_sck_en_i   ? spi_sck_i   : 1'b1;
  // CS0 -> DAT3
  assign sd_dat3_o = spi_cs_en_i[0] ? spi_cs_i[0] : 1'b1;
  // MOSI -> CMD
  assign sd_cmd_o  = spi_sd_en_i[0] ? spi_sd_i[0] : 1'b1;

  //////////////////////////////////////////////////////////////////////////
  // i2c pads
  //////////////////////////////////////////////////////////////////////////

  // output and enable go out as they are
  // pad side builds the open drain from the pair
  assign scl_pad_o = i2c_scl_i;
  assign scl_oe_o  = i2c_scl_en_i;
  assign sda_pad_o = i2c_sda_i;
  assign sda_oe_o  = i2c_sda_en_i;

  //////////////////////////////////////////////////////////////////////////
  // input synchronizers
  //////////////////////////////////////////////////////////////////////////

  // all four pads are asynchronous to soc_clk
  assign pad_async[lane_miso] = sd_dat0_i;
  assign pad_async[lane_scl]  = scl_pad_i;
  assign pad_async[lane_sda]  = sda_pad_i;
  assign pad_async[lane_cd]   = sd_cd_i;

  // stage 0 samples the pads, last stage feeds the SoC
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= pad_async;
      for (int unsigned i = 1; i < sync_stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign pad_sync = sync_q[sync_stages-1];

  // MISO on bit 1, output-only lines read back as zero
  assign spi_sd_o      = {2'b00, pad_sync[lane_miso], 1'b0};
  assign i2c_scl_o     = pad_sync[lane_scl];
  assign i2c_sda_o     = pad_sync[lane_sda];
  assign card_detect_o = pad_sync[lane_cd];

endmodule

// File: design/board_top.sv
// board glue top level
// rtc divider, fan PWM and the SD/I2C pad adapter of the FPGA carrier

`timescale 1ns/1ps

module board_top (
  input  logic                           soc_clk,
  input  logic                           rst_n,
  // fan
  input  board_timing_pkg::fan_setting_t fan_sw_i,
  output logic                           fan_pwm_o,
  // rtc to the SoC
  output logic                           rtc_o,
  // spi, SoC side
  input  logic                           spi_sck_i,
  input  logic                           spi_sck_en_i,
  input  board_pads_pkg::spi_cs_t        spi_cs_i,
  input  board_pads_pkg::spi_cs_t        spi_cs_en_i,
  input  board_pads_pkg::spi_sd_t        spi_sd_i,
  input  board_pads_pkg::spi_sd_t        spi_sd_en_i,
  output board_pads_pkg::spi_sd_t        spi_sd_o,
  // sd card pins
  output logic                           sd_sclk_o,
  output logic                           sd_cmd_o,
  output logic                           sd_dat3_o,
  input  logic                           sd_dat0_i,
  input  logic                           sd_cd_i,
  output logic                           card_detect_o,
  // i2c, SoC side
  input  logic                           i2c_scl_i,
  input  logic                           i2c_scl_en_i,
  input  logic                           i2c_sda_i,
  input  logic                           i2c_sda_en_i,
  output logic                           i2c_scl_o,
  output logic                           i2c_sda_o,
  // i2c pads
  output logic                           scl_pad_o,
  output logic                           scl_oe_o,
  output logic                           sda_pad_o,
  output logic                           sda_oe_o,
  input  logic                           scl_pad_i,
  input  logic                           sda_pad_i
);

  //////////////////////////////////////////////////////////////////////////
  // rtc
  //////////////////////////////////////////////////////////////////////////

  rtc_divider u_rtc_divider (
    .soc_clk (soc_clk),
    .rst_n   (rst_n),
    .rtc_o   (rtc_o)
  );

  //////////////////////////////////////////////////////////////////////////
  // fan
  //////////////////////////////////////////////////////////////////////////

  fan_pwm u_fan_pwm (
    .soc_clk   (soc_clk),
    .rst_n     (rst_n),
    .fan_sw_i  (fan_sw_i),
    .fan_pwm_o (fan_pwm_o)
  );

  //////////////////////////////////////////////////////////////////////////
  // pads
  //////////////////////////////////////////////////////////////////////////

  pad_adapter u_pad_adapter (
    .soc_clk       (soc_clk),
    .rst_n         (rst_n),
    .spi_sck_i     (spi_sck_i),
    .spi_sck_en_i  (spi_sck_en_i),
    .spi_cs_i      (spi_cs_i),
    .spi_cs_en_i   (spi_cs_en_i),
    .spi_sd_i      (spi_sd_i),
    .spi_sd_en_i   (spi_sd_en_i),
    .spi_sd_o      (spi_sd_o),
    .sd_sclk_o     (sd_sclk_o),
    .sd_cmd_o      (sd_cmd_o),
    .sd_dat3_o     (sd_dat3_o),
    .sd_dat0_i     (sd_dat0_i),
    .sd_cd_i       (sd_cd_i),
    .card_detect_o (card_detect_o),
    .i2c_scl_i     (i2c_scl_i),
    .i2c_scl_en_i  (i2c_scl_en_i),
    .i2c_sda_i     (i2c_sda_i),
    .i2c_sda_en_i  (i2c_sda_en_i),
    .scl_pad_o     (scl_pad_o),
    .scl_oe_o      (scl_oe_o),
    .sda_pad_o     (sda_pad_o),
    .sda_oe_o      (sda_oe_o),
    .scl_pad_i     (scl_pad_i),
    .sda_pad_i     (sda_pad_i),
    .i2c_scl_o     (i2c_scl_o),
    .i2c_sda_o     (i2c_sda_o)
  );

endmodule

// File: testbench/board_checker.sv
// board glue checker
// watches the DUT pins, works out the expected levels and counts errors

`timescale 1ns/1ps

`include "board_settings.svh"

module board_checker (
  input  logic                           soc_clk,
  input  logic                           rst_n,
  // current table row as driven by the testbench
  input  int                             row_idx_i,
  input  logic [127:0]                   test_name_i,
  input  logic [2:0]                     exp_sd_i,
  input  logic [3:0]                     exp_sync_i,
  // DUT inputs the checks depend on
  input  board_timing_pkg::fan_setting_t fan_sw_i,
  input  logic [3:0]                     i2c_soc_i,
  // DUT outputs
  input  logic                           rtc_i,
  input  logic                           fan_pwm_i,
  input  board_pads_pkg::spi_sd_t        spi_sd_rd_i,
  input  logic [2:0]                     sd_pads_i,
  input  logic [3:0]                     sync_i,
  input  logic [3:0]                     i2c_pads_i,
  // results
  output int                             mismatch_count_o,
  output int                             other_count_o,
  output int                             rows_checked_o
);

  // fan window skips one period after the change and counts the next two
  localparam int pwm_period   = `FAN_PRESCALE * `FAN_STEPS;
  localparam int window_first = pwm_period + 2;
  localparam int window_last  = 3 * pwm_period + 1;
  localparam int row_end      = 3 * pwm_period + 2;
  localparam int sync_delay   = `PAD_SYNC_STAGES;

  int         mismatches    = 0;
  int         others        = 0;
  int         rows_checked  = 0;
  int         rst_edges     = 0;
  int         run_edges     = 0;
  int         rtc_gap       = 0;
  int         row_last      = -1;
  int         row_cycle     = 0;
  int         pwm_high      = 0;
  logic       rtc_last      = 1'b0;
  logic [3:0] sync_exp_last = 4'b0000;
  logic [3:0] sync_old      = 4'b0000;

  task automatic compare_value(input logic [127:0] name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      mismatches++;
      $display("MISMATCH %0s %0s: expected 'h%0h, actual 'h%0h", name, what, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // rtc edge spacing
  //////////////////////////////////////////////////////////////////////////

  // sample 1 after release is the reference and the first edge comes 25 samples later
  task automatic check_rtc();
    rtc_gap++;
    if (rtc_i !== rtc_last) begin
      compare_value(test_name_i, "rtc_edge_gap", `RTC_DIV_HALF, rtc_gap);
      rtc_gap  = 0;
      rtc_last = rtc_i;
    end else if (rtc_gap > `RTC_DIV_HALF) begin
      others++;
      $display("rtc_o did not toggle within %0d cycles", `RTC_DIV_HALF);
      rtc_gap = 0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // per-row pad and fan checks
  //////////////////////////////////////////////////////////////////////////

  task automatic check_row();
    // new row seen at the first edge after the falling-edge drive
    if (row_idx_i != row_last) begin
      sync_old  = sync_exp_last;
      row_last  = row_idx_i;
      row_cycle = 0;
      pwm_high  = 0;
    end
    sync_exp_last = exp_sync_i;
    compare_value(test_name_i, "i2c_pads", 32'(i2c_soc_i), 32'(i2c_pads_i));
    compare_value(test_name_i, "spi_sd_unused", '0,
                  32'({spi_sd_rd_i[3:2], spi_sd_rd_i[0]}));
    if (row_idx_i >= 0) begin
      row_cycle++;
      // idle-high mapping shows up in the same cycle
      compare_value(test_name_i, "sd_pads", 32'(exp_sd_i), 32'(sd_pads_i));
      // old level until the chain has shifted twice
      if (row_cycle <= sync_delay) begin
        compare_value(test_name_i, "sync_hold", 32'(sync_old), 32'(sync_i));
      end else begin
        compare_value(test_name_i, "sync", 32'(exp_sync_i), 32'(sync_i));
      end
      if (row_cycle >= window_first && row_cycle <= window_last && fan_pwm_i) begin
        pwm_high++;
      end
      if (row_cycle == row_end) begin
        compare_value(test_name_i, "fan_high_cycles",
                      2 * int'(fan_sw_i) * `FAN_PRESCALE, pwm_high);
        rows_checked++;
      end
    end
  endtask

  // sampled on the rising edge while the falling-edge drive is stable
  always @(posedge soc_clk) begin
    if (!rst_n) begin
      // first edge may still show power-up levels
      rst_edges++;
      if (rst_edges > 1) begin
        compare_value("in_reset", "low_outputs", '0, 32'({rtc_i, fan_pwm_i, sync_i}));
      end
      run_edges = 0;
    end else begin
      run_edges++;
      if (run_edges == 1) begin
        // reference level for the rtc edge spacing
        rtc_gap  = 0;
        rtc_last = rtc_i;
      end else begin
        // one edge after release nothing has had time to rise
        if (run_edges == 2) begin
          compare_value("after_reset", "low_outputs", '0,
                        32'({rtc_i, fan_pwm_i, sync_i}));
        end
        check_rtc();
        check_row();
      end
    end
  end

  assign mismatch_count_o = mismatches;
  assign other_count_o    = others;
  assign rows_checked_o   = rows_checked;

endmodule

// File: testbench/tb_board_top.sv
// board glue testbench
// drives the stimulus table into board_top and bounds the run length

`timescale 1ns/1ps

`include "board_settings.svh"

module tb_board_top;

  localparam int num_rows       = 6;
  // three fan periods plus two cycles per row
  localparam int row_hold       = 3 * `FAN_PRESCALE * `FAN_STEPS + 2;
  localparam int timeout_cycles = num_rows * 200 + 500;

  // spi is {sck, sck_en, cs0, cs0_en, mosi, mosi_en}
  // i2c is {scl, scl_en, sda, sda_en}, pads and sync are {dat0, cd, scl, sda}
  // exp_sd is {sclk, dat3, cmd}
  typedef struct packed {
    logic [127:0] name;
    logic [3:0]   fan;
    logic [5:0]   spi;
    logic [3:0]   i2c;
    logic [3:0]   pads;
    logic [2:0]   exp_sd;
    logic [3:0]   exp_sync;
  } row_t;

  logic                           soc_clk;
  logic                           rst_n;
  board_timing_pkg::fan_setting_t fan_sw_i;
  logic                           fan_pwm_o;
  logic                           rtc_o;
  logic                           spi_sck_i;
  logic                           spi_sck_en_i;
  board_pads_pkg::spi_cs_t        spi_cs_i;
  board_pads_pkg::spi_cs_t        spi_cs_en_i;
  board_pads_pkg::spi_sd_t        spi_sd_i;
  board_pads_pkg::spi_sd_t        spi_sd_en_i;
  board_pads_pkg::spi_sd_t        spi_sd_o;
  logic                           sd_sclk_o;
  logic                           sd_cmd_o;
  logic                           sd_dat3_o;
  logic                           sd_dat0_i;
  logic                           sd_cd_i;
  logic                           card_detect_o;
  logic                           i2c_scl_i;
  logic                           i2c_scl_en_i;
  logic                           i2c_sda_i;
  logic                           i2c_sda_en_i;
  logic                           i2c_scl_o;
  logic                           i2c_sda_o;
  logic                           scl_pad_o;
  logic                           scl_oe_o;
  logic                           sda_pad_o;
  logic                           sda_oe_o;
  logic                           scl_pad_i;
  logic                           sda_pad_i;

  row_t        rows [num_rows];
  row_t        cur;
  int          cur_idx;
  int          cycle_count = 0;
  int          mismatch_count;
  int          other_count;
  int          rows_checked;
  logic [31:0] rnd;

  board_top dut0 (.*);

  board_checker u_checker (
    .soc_clk          (soc_clk),
    .rst_n            (rst_n),
    .row_idx_i        (cur_idx),
    .test_name_i      (cur.name),
    .exp_sd_i         (cur.exp_sd),
    .exp_sync_i       (cur.exp_sync),
    .fan_sw_i         (fan_sw_i),
    .i2c_soc_i        ({i2c_scl_i, i2c_scl_en_i, i2c_sda_i, i2c_sda_en_i}),
    .rtc_i            (rtc_o),
    .fan_pwm_i        (fan_pwm_o),
    .spi_sd_rd_i      (spi_sd_o),
    .sd_pads_i        ({sd_sclk_o, sd_dat3_o, sd_cmd_o}),
    .sync_i           ({spi_sd_o[1], card_detect_o, i2c_scl_o, i2c_sda_o}),
    .i2c_pads_i       ({scl_pad_o, scl_oe_o, sda_pad_o, sda_oe_o}),
    .mismatch_count_o (mismatch_count),
    .other_count_o    (other_count),
    .rows_checked_o   (rows_checked)
  );

  // 40 ns period
  always #20 soc_clk = ~soc_clk;

  always @(posedge soc_clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // unused spi lines get random levels, the mapping must ignore them
  task automatic drive_row(input int idx);
    cur     = rows[idx];
    cur_idx = idx;
    rnd     = $urandom();
    fan_sw_i = cur.fan;
    {spi_sck_i, spi_sck_en_i, spi_cs_i[0], spi_cs_en_i[0], spi_sd_i[0], spi_sd_en_i[0]} = cur.spi;
    {i2c_scl_i, i2c_scl_en_i, i2c_sda_i, i2c_sda_en_i} = cur.i2c;
    {sd_dat0_i, sd_cd_i, scl_pad_i, sda_pad_i} = cur.pads;
    spi_cs_i[1]      = rnd[0];
    spi_cs_en_i[1]   = rnd[1];
    spi_sd_i[3:1]    = rnd[4:2];
    spi_sd_en_i[3:1] = rnd[7:5];
  endtask

  initial begin
    rows[0] = '{"fan_off_idle",   4'd0,  6'b000000, 4'b0000, 4'b0000, 3'b111, 4'b0000};
    rows[1] = '{"fan_full_drive", 4'd15, 6'b010101, 4'b0101, 4'b1111, 3'b000, 4'b1111};
    rows[2] = '{"fan_third",      4'd5,  6'b110111, 4'b1010, 4'b1010, 3'b101, 4'b1010};
    rows[3] = '{"fan_half_cs_off", 4'd8, 6'b010010, 4'b1101, 4'b0101, 3'b011, 4'b0101};
    rows[4] = '{"fan_one_step",   4'd1,  6'b101101, 4'b0111, 4'b1001, 3'b110, 4'b1001};
    rows[5] = '{"fan_most",       4'd14, 6'b011001, 4'b1111, 4'b0110, 3'b010, 4'b0110};
    rnd     = $urandom(32'h134b_3a48);
    soc_clk = 1'b0;
    rst_n   = 1'b0;
    cur      = '0;
    cur.name = "before_rows";
    cur_idx  = -1;
    {fan_sw_i, spi_sck_i, spi_sck_en_i, spi_cs_i, spi_cs_en_i} = '0;
    {spi_sd_i, spi_sd_en_i, sd_dat0_i, sd_cd_i} = '0;
    {i2c_scl_i, i2c_scl_en_i, i2c_sda_i, i2c_sda_en_i, scl_pad_i, sda_pad_i} = '0;
    repeat (3) @(posedge soc_clk);
    @(negedge soc_clk);
    rst_n = 1'b1;
    repeat (4) @(negedge soc_clk);
    for (int i = 0; i < num_rows; i++) begin
      drive_row(i);
      repeat (row_hold) @(negedge soc_clk);
    end
    if (rows_checked != num_rows) begin
      $display("only %0d of %0d rows reached their fan check", rows_checked, num_rows);
    end
    $display("errors: %0d mismatches, %0d other failures, %0d of %0d rows checked",
             mismatch_count, other_count, rows_checked, num_rows);
    if (mismatch_count == 0 && other_count == 0 && rows_checked == num_rows) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+include
design/board_timing_pkg.sv
design/board_pads_pkg.sv
design/rtc_divider.sv
design/fan_pwm.sv
design/pad_adapter.sv
design/board_top.sv
testbench/board_checker.sv
testbench/tb_board_top.sv

// File: run.sh
#!/bin/sh
# builds the board glue testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="$build_dir/sim.log"

mkdir -p "$build_dir"
if [ $? -ne 0 ]; then
  echo "could not create $build_dir"
  exit 1
fi

verilator --binary --timing -j 0 --timescale 1ns/1ps -f all.f \
  --top-module tb_board_top -Mdir "$build_dir/obj_dir" -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$build_dir/obj_dir/tb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$log_file"; then
  exit 1
fi
exit 0
